// File: cong_man_pkg.sv
/* Sizes, vector types and bundles shared by the congestion manager
   Queue ids are egress port then queue-in-port; four queues per port are assumed */

`default_nettype none

package cong_man_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int num_egr_ports      = 4;
    localparam int queues_per_port    = 4;
    localparam int num_queues         = num_egr_ports * queues_per_port;
    localparam int data_bytes         = 8;
    localparam int counters_per_queue = 2;
    localparam int occ_width          = 16;
    localparam int len_width          = 11;

    ////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [$clog2(num_queues)-1:0] queue_id_t;
    typedef logic [2:0]                    prio_t;
    typedef logic [len_width-1:0]          byte_len_t;
    typedef logic [occ_width-1:0]          occupancy_t;
    typedef logic [31:0]                   counter_t;
    typedef logic [data_bytes*8-1:0]       word_data_t;
    typedef logic [data_bytes-1:0]         word_keep_t;

    ////////////////////////////////////////////////////////////
    // Encodings

    typedef enum logic [$clog2(counters_per_queue)-1:0] {
        drop_policer    = 1'b0,
        drop_queue_full = 1'b1
    } drop_reason_e;

    // Code 3 is left undefined and answered with an error
    typedef enum logic [1:0] {
        op_read       = 2'd0,
        op_read_clear = 2'd1,
        op_clear_all  = 2'd2
    } cntr_op_e;

    typedef enum logic {
        cntr_init,
        cntr_active
    } cntr_state_e;

    ////////////////////////////////////////////////////////////
    // Bundles

    typedef struct packed {
        logic [$clog2(num_egr_ports)-1:0] egress_port;
        prio_t                            prio;
        byte_len_t                        byte_length;
        logic                             policer_mark;
    } pkt_meta_t;

    typedef struct packed {
        word_data_t data;
        word_keep_t keep;
        logic       last;
    } pkt_word_t;

    typedef struct packed {
        queue_id_t  queue;
        occupancy_t bytes;
    } release_t;

    typedef struct packed {
        logic       write;
        queue_id_t  queue;
        occupancy_t wdata;
    } thresh_req_t;

    typedef struct packed {
        occupancy_t rdata;
        logic       error;
    } thresh_rsp_t;

    typedef struct packed {
        cntr_op_e     op;
        queue_id_t    queue;
        drop_reason_e reason;
    } cntr_req_t;

    typedef struct packed {
        counter_t rdata;
        logic     error;
    } cntr_rsp_t;

    typedef struct packed {
        queue_id_t    queue;
        drop_reason_e reason;
    } drop_event_t;

endpackage

`default_nettype wire

// File: admission_pipeline.sv
/* Three-stage word pipeline; metadata is taken only from the first word of a packet
   Threshold and occupancy must come back combinationally for dec_queue */

`timescale 1ns/10ps
`default_nettype none

module admission_pipeline import cong_man_pkg::*; (
    input  var logic       counter_access,
    input  var logic       arst_n,
    input  var logic       in_valid,
    input  var pkt_word_t  in_word,
    input  var pkt_meta_t  in_meta,
    input  var occupancy_t threshold,
    input  var occupancy_t occupancy,
    output queue_id_t      dec_queue,
    output logic           admit_valid,
    output byte_len_t      admit_bytes,
    output logic           drop_valid,
    output drop_event_t    drop_event,
    output logic           out_valid,
    output pkt_word_t      out_word,
    output queue_id_t      out_queue
);

    // Emergency, management and voice get their own queue, the rest share one
    function automatic logic [$clog2(queues_per_port)-1:0] prio_to_queue(input prio_t prio);
        case (prio)
            3'd7:    return 2'd3;
            3'd6:    return 2'd2;
            3'd5:    return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

    logic       in_sop;
    logic       s0_valid;
    logic       s0_sop;
    pkt_word_t  s0_word;
    pkt_meta_t  s0_meta;
    queue_id_t  s0_queue;

    logic                 drop_hold;
    logic                 policer_drop;
    logic                 full_drop;
    logic                 sop_drop;
    logic                 drop_now;
    logic [occ_width:0]   occ_plus_len;

    ////////////////////////////////////////////////////////////
    // Stage 0

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            in_sop   <= 1'b1;
            s0_valid <= 1'b0;
            s0_sop   <= 1'b0;
        end else begin
            s0_valid <= in_valid;
            s0_sop   <= in_valid & in_sop;
            if (in_valid) begin
                in_sop <= in_word.last;
            end
        end
    end

    // Metadata and queue stay put for the body words of the packet
    always_ff @(posedge counter_access) begin
        s0_word <= in_word;
        if (in_valid && in_sop) begin
            s0_meta  <= in_meta;
            s0_queue <= {in_meta.egress_port, prio_to_queue(in_meta.prio)};
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1

    assign dec_queue    = s0_queue;
    assign occ_plus_len = {1'b0, occupancy} + (occ_width+1)'(s0_meta.byte_length);

    // Management and emergency traffic bypass the ingress policer
    assign policer_drop = s0_meta.policer_mark && (s0_meta.prio < 3'd6);
    assign full_drop    = occ_plus_len > {1'b0, threshold};
    assign sop_drop     = policer_drop | full_drop;
    assign drop_now     = s0_sop ? sop_drop : drop_hold;

    assign admit_valid       = s0_valid & s0_sop & ~sop_drop;
    assign admit_bytes       = s0_meta.byte_length;
    assign drop_valid        = s0_valid & s0_sop & sop_drop;
    assign drop_event.queue  = s0_queue;
    assign drop_event.reason = policer_drop ? drop_policer : drop_queue_full;

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            drop_hold <= 1'b0;
        end else if (s0_valid && s0_sop) begin
            drop_hold <= sop_drop;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s0_valid & ~drop_now;
        end
    end

    always_ff @(posedge counter_access) begin
        out_word  <= s0_word;
        out_queue <= s0_queue;
    end

endmodule

`default_nettype wire

// File: drop_threshold_table.sv
/* Per-queue drop thresholds, all ones after reset; one response outstanding at a time
   A write is seen by drop decisions from the following cycle */

`timescale 1ns/10ps
`default_nettype none

module drop_threshold_table import cong_man_pkg::*; (
    input  var logic        counter_access,
    input  var logic        arst_n,
    input  var queue_id_t   dec_queue,
    output occupancy_t      threshold,
    input  var logic        thresh_req_valid,
    input  var thresh_req_t thresh_req,
    output logic            thresh_req_ready,
    output logic            thresh_rsp_valid,
    output thresh_rsp_t     thresh_rsp,
    input  var logic        thresh_rsp_ready
);

    occupancy_t thresh_q [num_queues];
    logic       req_xfer;

    assign thresh_req_ready = ~thresh_rsp_valid;
    assign req_xfer         = thresh_req_valid & thresh_req_ready;

    // Lookup for the decision stage
    assign threshold = thresh_q[dec_queue];

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            thresh_q         <= '{default: '1};
            thresh_rsp_valid <= 1'b0;
        end else begin
            if (req_xfer) begin
                thresh_rsp_valid <= 1'b1;
                if (thresh_req.write) begin
                    thresh_q[thresh_req.queue] <= thresh_req.wdata;
                end
            end else if (thresh_rsp_ready) begin
                thresh_rsp_valid <= 1'b0;
            end
        end
    end

    // Writes echo the new value, reads return the stored one
    always_ff @(posedge counter_access) begin
        if (req_xfer) begin
            thresh_rsp.rdata <= thresh_req.write ? thresh_req.wdata : thresh_q[thresh_req.queue];
            // Every 4-bit queue index is a real table entry
            thresh_rsp.error <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: queue_occupancy.sv
/* Byte occupancy per queue, zero after reset, saturating at zero and at all ones
   Admit and release for the same queue in one cycle both apply */

`timescale 1ns/10ps
`default_nettype none

module queue_occupancy import cong_man_pkg::*; (
    input  var logic       counter_access,
    input  var logic       arst_n,
    input  var queue_id_t  dec_queue,
    output occupancy_t     occupancy,
    input  var logic       admit_valid,
    input  var byte_len_t  admit_bytes,
    input  var logic       release_valid,
    input  var release_t   release_in
);

    occupancy_t occ_q    [num_queues];
    occupancy_t occ_next [num_queues];

    assign occupancy = occ_q[dec_queue];

    always_comb begin
        logic [occ_width:0] total;
        logic [occ_width:0] sub;
        logic [occ_width:0] diff;
        for (int q = 0; q < num_queues; q++) begin
            total = {1'b0, occ_q[q]};
            sub   = '0;
            if (admit_valid && dec_queue == queue_id_t'(q)) begin
                total = total + (occ_width+1)'(admit_bytes);
            end
            if (release_valid && release_in.queue == queue_id_t'(q)) begin
                sub = {1'b0, release_in.bytes};
            end
            diff = total - sub;
            // Clamp below at zero, above at the register maximum
            if (total < sub) begin
                occ_next[q] = '0;
            end else if (diff[occ_width]) begin
                occ_next[q] = '1;
            end else begin
                occ_next[q] = diff[occ_width-1:0];
            end
        end
    end

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            occ_q <= '{default: '0};
        end else begin
            occ_q <= occ_next;
        end
    end

endmodule

`default_nettype wire

// File: drop_counters.sv
/* Saturating drop counters per queue and reason, swept to zero for 32 cycles after reset
   Drops arriving during the sweep are not counted; access stalls until it ends */

`timescale 1ns/10ps
`default_nettype none

module drop_counters import cong_man_pkg::*; (
    input  var logic        counter_access,
    input  var logic        arst_n,
    input  var logic        drop_valid,
    input  var drop_event_t drop_event,
    input  var logic        cntr_req_valid,
    input  var cntr_req_t   cntr_req,
    output logic            cntr_req_ready,
    output logic            cntr_rsp_valid,
    output cntr_rsp_t       cntr_rsp,
    input  var logic        cntr_rsp_ready
);

    // Counter index is queue then reason
    typedef logic [$clog2(num_queues*counters_per_queue)-1:0] cntr_idx_t;

    counter_t    cntr_q [num_queues*counters_per_queue];
    cntr_state_e state;
    cntr_idx_t   init_idx;
    cntr_idx_t   ev_idx;
    cntr_idx_t   req_idx;
    logic        req_xfer;
    logic        inc_we;
    logic        clr_we;
    logic        clr_same;
    counter_t    ev_count;
    counter_t    inc_value;

    assign ev_idx  = {drop_event.queue, drop_event.reason};
    assign req_idx = {cntr_req.queue, cntr_req.reason};

    assign cntr_req_ready = (state == cntr_active) & ~cntr_rsp_valid;
    assign req_xfer       = cntr_req_valid & cntr_req_ready;

    assign inc_we   = (state == cntr_active) & drop_valid;
    assign clr_we   = req_xfer & (cntr_req.op == op_read_clear);
    assign clr_same = clr_we & (req_idx == ev_idx);

    // Increment after a same-cycle clear starts again from zero
    assign ev_count  = cntr_q[ev_idx];
    assign inc_value = clr_same ? counter_t'(1) :
                       (&ev_count) ? ev_count : ev_count + counter_t'(1);

    ////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge counter_access or negedge arst_n) begin
        if (!arst_n) begin
            state          <= cntr_init;
            init_idx       <= '0;
            cntr_rsp_valid <= 1'b0;
        end else begin
            case (state)
                cntr_init: begin
                    init_idx <= init_idx + cntr_idx_t'(1);
                    if (&init_idx) begin
                        state <= cntr_active;
                    end
                end
                cntr_active: begin
                    if (req_xfer && cntr_req.op == op_clear_all) begin
                        state <= cntr_init;
                    end
                end
                default: state <= cntr_init;
            endcase

            if (req_xfer) begin
                cntr_rsp_valid <= 1'b1;
            end else if (cntr_rsp_ready) begin
                cntr_rsp_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Counter storage and response data

    always_ff @(posedge counter_access) begin
        if (state == cntr_init) begin
            cntr_q[init_idx] <= '0;
        end
        if (clr_we) begin
            cntr_q[req_idx] <= '0;
        end
        if (inc_we) begin
            cntr_q[ev_idx] <= inc_value;
        end

        if (req_xfer) begin
            cntr_rsp.rdata <= '0;
            cntr_rsp.error <= 1'b0;
            case (cntr_req.op)
                op_read, op_read_clear: cntr_rsp.rdata <= cntr_q[req_idx];
                op_clear_all:           cntr_rsp.rdata <= '0;
                default:                cntr_rsp.error <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cong_man_top.sv
/* Congestion manager admission path; input is always accepted, output has no back-pressure
   Words leave 2 cycles after they enter, or never when their packet is dropped */

`timescale 1ns/10ps
`default_nettype none

module cong_man_top import cong_man_pkg::*; (
    input  var logic        counter_access,
    input  var logic        arst_n,
    // Packet stream
    input  var logic        in_valid,
    input  var pkt_word_t   in_word,
    input  var pkt_meta_t   in_meta,
    output logic            out_valid,
    output pkt_word_t       out_word,
    output queue_id_t       out_queue,
    // Dequeue feedback
    input  var logic        release_valid,
    input  var release_t    release_in,
    // Threshold configuration
    input  var logic        thresh_req_valid,
    input  var thresh_req_t thresh_req,
    output logic            thresh_req_ready,
    output logic            thresh_rsp_valid,
    output thresh_rsp_t     thresh_rsp,
    input  var logic        thresh_rsp_ready,
    // Drop counter access
    input  var logic        cntr_req_valid,
    input  var cntr_req_t   cntr_req,
    output logic            cntr_req_ready,
    output logic            cntr_rsp_valid,
    output cntr_rsp_t       cntr_rsp,
    input  var logic        cntr_rsp_ready
);

    queue_id_t   dec_queue;
    occupancy_t  threshold;
    occupancy_t  occupancy;
    logic        admit_valid;
    byte_len_t   admit_bytes;
    logic        drop_valid;
    drop_event_t drop_event;

    admission_pipeline i_pipeline (
        .counter_access, .arst_n,
        .in_valid, .in_word, .in_meta,
        .threshold, .occupancy, .dec_queue,
        .admit_valid, .admit_bytes,
        .drop_valid, .drop_event,
        .out_valid, .out_word, .out_queue
    );

    drop_threshold_table i_thresh (
        .counter_access, .arst_n,
        .dec_queue, .threshold,
        .thresh_req_valid, .thresh_req, .thresh_req_ready,
        .thresh_rsp_valid, .thresh_rsp, .thresh_rsp_ready
    );

    queue_occupancy i_occupancy (
        .counter_access, .arst_n,
        .dec_queue, .occupancy,
        .admit_valid, .admit_bytes,
        .release_valid, .release_in
    );

    drop_counters i_counters (
        .counter_access, .arst_n,
        .drop_valid, .drop_event,
        .cntr_req_valid, .cntr_req, .cntr_req_ready,
        .cntr_rsp_valid, .cntr_rsp, .cntr_rsp_ready
    );

endmodule

`default_nettype wire

// File: tb_cong_man_model.svh
/* Reference model, LFSR source and value check, included inside the testbench module
   Occupancy and counters are updated when a start-of-packet word is driven */

`ifndef TB_CONG_MAN_MODEL_SVH
`define TB_CONG_MAN_MODEL_SVH

logic [31:0] lfsr_state = 32'd10;
int          check_errors = 0;
occupancy_t  model_thresh [num_queues] = '{default: '1};
int          model_occ    [num_queues] = '{default: 0};
counter_t    model_cnt    [num_queues*counters_per_queue] = '{default: '0};

// Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < n; i++) begin
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        value = {value[62:0], lsb};
    end
    return value;
endfunction

task automatic check_equal(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
        check_errors++;
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                 $time, name, expected, actual);
    end
endtask

// Emergency 7, management 6, voice 5, data 0 to 4
function automatic queue_id_t queue_of(input pkt_meta_t meta);
    logic [1:0] sub;
    case (meta.prio)
        3'd7:    sub = 2'd3;
        3'd6:    sub = 2'd2;
        3'd5:    sub = 2'd1;
        default: sub = 2'd0;
    endcase
    return {meta.egress_port, sub};
endfunction

function automatic void count_drop(input int idx);
    if (model_cnt[idx] != '1) begin
        model_cnt[idx] = model_cnt[idx] + 1;
    end
endfunction

// Policer first, then the queue threshold
function automatic logic decide_admission(input pkt_meta_t meta);
    int q;
    int sum;
    q   = int'(queue_of(meta));
    sum = model_occ[q] + int'(meta.byte_length);
    if (meta.policer_mark && meta.prio < 3'd6) begin
        count_drop(q * 2);
        return 1'b1;
    end else if (sum > int'(model_thresh[q])) begin
        count_drop(q * 2 + 1);
        return 1'b1;
    end
    model_occ[q] = (sum > 65535) ? 65535 : sum;
    return 1'b0;
endfunction

function automatic void apply_release(input int q, input int bytes);
    model_occ[q] = (bytes > model_occ[q]) ? 0 : model_occ[q] - bytes;
endfunction

`endif

// File: tb_cong_man.sv
/* Random traffic against an in-testbench model; the LFSR seed is fixed so runs repeat
   Each admitted word is expected on the output exactly 2 cycles after it is driven */

`timescale 1ns/10ps
`default_nettype none

module tb_cong_man import cong_man_pkg::*;;

    localparam int wait_limit = 100;

    typedef struct packed {
        logic [31:0] cycle;
        pkt_word_t   word;
        queue_id_t   queue;
    } exp_word_t;

    logic        counter_access;
    logic        arst_n;
    logic        in_valid;
    pkt_word_t   in_word;
    pkt_meta_t   in_meta;
    logic        out_valid;
    pkt_word_t   out_word;
    queue_id_t   out_queue;
    logic        release_valid;
    release_t    release_in;
    logic        thresh_req_valid;
    thresh_req_t thresh_req;
    logic        thresh_req_ready;
    logic        thresh_rsp_valid;
    thresh_rsp_t thresh_rsp;
    logic        thresh_rsp_ready;
    logic        cntr_req_valid;
    cntr_req_t   cntr_req;
    logic        cntr_req_ready;
    logic        cntr_rsp_valid;
    cntr_rsp_t   cntr_rsp;
    logic        cntr_rsp_ready;

    int          cycle = 0;
    int          timeout_errors = 0;
    int          out_count = 0;
    exp_word_t   exp_q [$];

    `include "tb_cong_man_model.svh"

    cong_man_top i_dut (.*);

    always #5 counter_access = ~counter_access;

    always @(posedge counter_access) begin
        cycle <= cycle + 1;
    end

    // Output monitor, sampled mid-cycle
    always @(negedge counter_access) begin
        if (arst_n) begin
            if (out_valid) begin
                out_count++;
            end
            if (exp_q.size() > 0 && exp_q[0].cycle == 32'(cycle)) begin
                check_equal("out_valid", 64'(1), 64'(out_valid));
                check_equal("out_word.data", exp_q[0].word.data, out_word.data);
                check_equal("out_word.keep", 64'(exp_q[0].word.keep), 64'(out_word.keep));
                check_equal("out_word.last", 64'(exp_q[0].word.last), 64'(out_word.last));
                check_equal("out_queue", 64'(exp_q[0].queue), 64'(out_queue));
                void'(exp_q.pop_front());
            end else begin
                check_equal("out_valid", 64'(0), 64'(out_valid));
            end
        end
    end

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic step();
        @(posedge counter_access);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Port transactions

    task automatic thresh_access(input logic write, input int q, input occupancy_t wdata,
                                 output occupancy_t rdata);
        int n;
        thresh_req_valid = 1'b1;
        thresh_req       = '{write: write, queue: queue_id_t'(q), wdata: wdata};
        n = 0;
        while (!thresh_req_ready && n < wait_limit) begin
            step();
            n++;
        end
        if (!thresh_req_ready) begin
            report_timeout("threshold port never accepted the request");
        end
        step();
        thresh_req_valid = 1'b0;
        n = 0;
        while (!thresh_rsp_valid && n < wait_limit) begin
            step();
            n++;
        end
        if (!thresh_rsp_valid) begin
            report_timeout("threshold port gave no response");
        end
        rdata = thresh_rsp.rdata;
        // All 16 queue ids are valid table entries
        check_equal("thresh_rsp.error", 64'(0), 64'(thresh_rsp.error));
        step();
    endtask

    task automatic cntr_access(input cntr_op_e op, input int q, input int reason,
                               output counter_t rdata, output logic error);
        int n;
        cntr_req_valid = 1'b1;
        cntr_req       = '{op: op, queue: queue_id_t'(q), reason: drop_reason_e'(reason[0])};
        n = 0;
        // Also covers the init sweep after reset and after clear-all
        while (!cntr_req_ready && n < wait_limit) begin
            step();
            n++;
        end
        if (!cntr_req_ready) begin
            report_timeout("counter port never accepted the request");
        end
        step();
        cntr_req_valid = 1'b0;
        n = 0;
        while (!cntr_rsp_valid && n < wait_limit) begin
            step();
            n++;
        end
        if (!cntr_rsp_valid) begin
            report_timeout("counter port gave no response");
        end
        rdata = cntr_rsp.rdata;
        error = cntr_rsp.error;
        step();
    endtask

    task automatic compare_counters(input logic random_clear);
        counter_t rdata;
        logic     error;
        cntr_op_e op;
        for (int i = 0; i < num_queues * counters_per_queue; i++) begin
            op = (random_clear && rand_bits(1) == 64'd1) ? op_read_clear : op_read;
            cntr_access(op, i / 2, i % 2, rdata, error);
            check_equal("cntr_rsp.rdata", 64'(model_cnt[i]), 64'(rdata));
            check_equal("cntr_rsp.error", 64'(0), 64'(error));
            if (op == op_read_clear) begin
                model_cnt[i] = '0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Packet stream

    task automatic send_packet(input int port, input int prio, input int len,
                               input logic mark, output logic dropped);
        pkt_meta_t   meta;
        exp_word_t   entry;
        logic [63:0] junk;
        int          words;
        int          gap;
        meta    = '{egress_port: 2'(port), prio: prio_t'(prio),
                    byte_length: byte_len_t'(len), policer_mark: mark};
        dropped = decide_admission(meta);
        words   = (len + 7) / 8;
        for (int w = 0; w < words; w++) begin
            junk         = rand_bits(17);
            in_valid     = 1'b1;
            in_word.data = rand_bits(64);
            in_word.last = (w == words - 1);
            in_word.keep = (w == words - 1 && len % 8 != 0) ?
                           word_keep_t'((1 << (len % 8)) - 1) : '1;
            // Body words carry junk metadata that must be ignored
            in_meta      = (w == 0) ? meta : junk[16:0];
            if (!dropped) begin
                entry = '{cycle: 32'(cycle + 2), word: in_word, queue: queue_of(meta)};
                exp_q.push_back(entry);
            end
            step();
        end
        in_valid = 1'b0;
        gap = int'(rand_bits(2));
        for (int g = 0; g < gap; g++) begin
            step();
        end
    endtask

    task automatic release_bytes(input int q, input int bytes);
        release_valid = 1'b1;
        release_in    = '{queue: queue_id_t'(q), bytes: occupancy_t'(bytes)};
        apply_release(q, bytes);
        step();
        release_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < wait_limit) begin
            step();
            n++;
        end
        if (exp_q.size() > 0) begin
            report_timeout("expected output words never appeared");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        occupancy_t rd;
        occupancy_t thr;
        counter_t   crd;
        logic       err;
        logic       dropped;
        int         n;
        counter_access   = 1'b0;
        arst_n           = 1'b0;
        in_valid         = 1'b0;
        in_word          = '0;
        in_meta          = '0;
        release_valid    = 1'b0;
        release_in       = '0;
        thresh_req_valid = 1'b0;
        thresh_req       = '0;
        thresh_rsp_ready = 1'b1;
        cntr_req_valid   = 1'b0;
        cntr_req         = '0;
        cntr_rsp_ready   = 1'b1;
        repeat (16) @(posedge counter_access);
        #1;
        arst_n = 1'b1;

        // Counters clear themselves after reset, thresholds start at all ones
        n = 0;
        while (!cntr_req_ready && n < wait_limit) begin
            step();
            n++;
        end
        if (!cntr_req_ready) begin
            report_timeout("counters never left the init sweep");
        end
        compare_counters(1'b0);
        for (int q = 0; q < num_queues; q++) begin
            thresh_access(1'b0, q, '0, rd);
            check_equal("thresh_rsp.rdata", 64'(model_thresh[q]), 64'(rd));
        end

        // Thresholds of at least 256 bytes, so one 256-byte packet always fits an empty queue
        for (int q = 0; q < num_queues; q++) begin
            thr = occupancy_t'(256 + int'(rand_bits(11)));
            thresh_access(1'b1, q, thr, rd);
            check_equal("thresh_rsp.rdata", 64'(thr), 64'(rd));
            model_thresh[q] = thr;
        end
        for (int q = 0; q < num_queues; q++) begin
            thresh_access(1'b0, q, '0, rd);
            check_equal("thresh_rsp.rdata", 64'(model_thresh[q]), 64'(rd));
        end

        // Unmarked traffic fills the queues until drops start
        for (int k = 0; k < 150; k++) begin
            send_packet(int'(rand_bits(2)), int'(rand_bits(3)), 1 + int'(rand_bits(9)),
                        1'b0, dropped);
        end
        drain_outputs();

        // Empty every queue, then marked traffic
        for (int q = 0; q < num_queues; q++) begin
            release_bytes(q, 65535);
        end
        for (int prio = 5; prio <= 7; prio++) begin
            for (int k = 0; k < 6; k++) begin
                send_packet(int'(rand_bits(2)), prio, 1 + int'(rand_bits(8)), 1'b1, dropped);
            end
        end
        drain_outputs();

        // Fill one data queue per port, then free room for one more packet
        for (int p = 0; p < num_egr_ports; p++) begin
            dropped = 1'b0;
            for (int k = 0; k < 12 && !dropped; k++) begin
                send_packet(p, 0, 256, 1'b0, dropped);
            end
            release_bytes(p * queues_per_port, 512);
            drain_outputs();
            n = out_count;
            send_packet(p, 0, 256, 1'b0, dropped);
            drain_outputs();
            check_equal("out_valid words after release", 64'(256 / data_bytes),
                        64'(out_count - n));
        end
        drain_outputs();

        // Counter access ops
        compare_counters(1'b1);
        compare_counters(1'b0);
        cntr_access(cntr_op_e'(2'd3), 0, 0, crd, err);
        check_equal("cntr_rsp.error", 64'(1), 64'(err));
        cntr_access(op_clear_all, 0, 0, crd, err);
        check_equal("cntr_rsp.rdata", 64'(0), 64'(crd));
        check_equal("cntr_rsp.error", 64'(0), 64'(err));
        model_cnt = '{default: '0};
        compare_counters(1'b0);

        $display("Check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cong_man_pkg.sv
admission_pipeline.sv
drop_threshold_table.sv
queue_occupancy.sv
drop_counters.sv
cong_man_top.sv
tb_cong_man.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass message shows up
verilator --binary --timing -j 0 -f vlog.f --top-module tb_cong_man -o tb_cong_man_sim \
    && ./obj_dir/tb_cong_man_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }
